// ==== common/sccb_pkg.sv ====
`default_nettype none

package sccb_pkg;

  // Bit-level commands understood by the PHY
  typedef enum logic [2 : 0] {
    NOP,
    START,
    STOP,
    WRITE,
    READ
  } phy_cmd_t;

  localparam int CLK_FREQ = 10_000_000;
  localparam int SCL_FREQ = 400_000;

  // One SCL period is split into four equal quarters
  localparam int SCL_QUARTER   = CLK_FREQ / ( 4 * SCL_FREQ );
  localparam int SCL_QUARTER_W = $clog2( SCL_QUARTER );

  localparam logic [SCL_QUARTER_W - 1 : 0] QUARTER_LAST = SCL_QUARTER_W'( SCL_QUARTER - 1 );

  localparam logic [1 : 0] RESP_OKAY   = 2'b00;
  localparam logic [1 : 0] RESP_SLVERR = 2'b10;

  localparam int AXI_ADDR_W = 16;
  localparam int AXI_DATA_W = 32;

endpackage

`default_nettype wire

// ==== i2c_phy/i2c_master_phy.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2c_master_phy (
  input  wire                clk_i,
  input  wire                srst_i,
  input  var sccb_pkg::phy_cmd_t cmd_i,
  input  wire                data_i,
  output logic               data_o,
  output logic               cmd_done_o,
  input  wire                sda_i,
  output logic               sda_o,
  output logic               sda_oe_o,
  input  wire                scl_i,
  output logic               scl_o,
  output logic               scl_oe_o
);

logic [sccb_pkg::SCL_QUARTER_W - 1 : 0] quarter_cnt;
logic [1 : 0]                           phase;
logic                                   quarter_end;
logic                                   active;
logic [1 : 0]                           sda_sync;
logic [1 : 0]                           scl_sync;
logic                                   sda_oe_next;
logic                                   scl_oe_next;
logic                                   sample_en;

assign active      = cmd_i != sccb_pkg::NOP;
assign quarter_end = quarter_cnt == sccb_pkg::QUARTER_LAST;

// Open-drain pads only ever pull low
assign sda_o = 1'b0;
assign scl_o = 1'b0;

// Counters sit at zero while idle so a new command starts on a clean quarter
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      quarter_cnt <= '0;
      phase       <= '0;
    end
  else
    if( !active )
      begin
        quarter_cnt <= '0;
        phase       <= '0;
      end
    else
      if( quarter_end )
        begin
          quarter_cnt <= '0;
          phase       <= phase + 2'd1;
        end
      else
        quarter_cnt <= quarter_cnt + 1'b1;

// Last clock of the fourth quarter
assign cmd_done_o = active && ( phase == 2'd3 ) && quarter_end;

// SCL is high during quarters 1 and 2 of a data bit
always_comb
  begin
    sda_oe_next = 1'b0;
    scl_oe_next = 1'b0;
    case( cmd_i )
      sccb_pkg::START:
        begin
          sda_oe_next = phase[1];
          scl_oe_next = phase == 2'd3;
        end
      sccb_pkg::STOP:
        begin
          sda_oe_next = !phase[1];
          scl_oe_next = phase == 2'd0;
        end
      sccb_pkg::WRITE:
        begin
          sda_oe_next = !data_i;
          scl_oe_next = ( phase == 2'd0 ) || ( phase == 2'd3 );
        end
      sccb_pkg::READ:
        begin
          sda_oe_next = 1'b0;
          scl_oe_next = ( phase == 2'd0 ) || ( phase == 2'd3 );
        end
      default:
        begin
          sda_oe_next = 1'b0;
          scl_oe_next = 1'b0;
        end
    endcase
  end

// Registered pad enables keep both lines free of decode glitches
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      sda_oe_o <= 1'b0;
      scl_oe_o <= 1'b0;
    end
  else
    begin
      sda_oe_o <= sda_oe_next;
      scl_oe_o <= scl_oe_next;
    end

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      sda_sync <= 2'b11;
      scl_sync <= 2'b11;
    end
  else
    begin
      sda_sync <= { sda_sync[0], sda_i };
      scl_sync <= { scl_sync[0], scl_i };
    end

// Sample point is the middle of the SCL high time
assign sample_en = ( cmd_i == sccb_pkg::READ ) && ( phase == 2'd1 ) && quarter_end;

// A bus whose SCL never went high reads back as a released line
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    data_o <= 1'b1;
  else
    if( sample_en )
      data_o <= scl_sync[1] ? sda_sync[1] : 1'b1;

endmodule

`default_nettype wire

// ==== sccb_master/sccb_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module sccb_master (
  input  wire                                  clk_i,
  input  wire                                  srst_i,
  input  wire                                  s_awvalid_i,
  output logic                                 s_awready_o,
  input  wire  [sccb_pkg::AXI_ADDR_W - 1 : 0]  s_awaddr_i,
  input  wire                                  s_wvalid_i,
  output logic                                 s_wready_o,
  input  wire  [sccb_pkg::AXI_DATA_W - 1 : 0]  s_wdata_i,
  output logic                                 s_bvalid_o,
  input  wire                                  s_bready_i,
  output logic [1 : 0]                         s_bresp_o,
  input  wire                                  s_arvalid_i,
  output logic                                 s_arready_o,
  input  wire  [sccb_pkg::AXI_ADDR_W - 1 : 0]  s_araddr_i,
  output logic                                 s_rvalid_o,
  input  wire                                  s_rready_i,
  output logic [sccb_pkg::AXI_DATA_W - 1 : 0]  s_rdata_o,
  output logic [1 : 0]                         s_rresp_o,
  input  wire  [6 : 0]                         slave_addr_i,
  output sccb_pkg::phy_cmd_t                   phy_cmd_o,
  output logic                                 tx_bit_o,
  input  wire                                  rx_bit_i,
  input  wire                                  cmd_done_i
);

typedef enum logic [3 : 0] {
  IDLE_S,
  START_0_S,
  SLAVE_ADDR_0_S,
  ACK_0_S,
  SUB_ADDR_MSB_S,
  ACK_1_S,
  SUB_ADDR_LSB_S,
  ACK_2_S,
  START_1_S,
  SLAVE_ADDR_1_S,
  ACK_3_S,
  WR_DATA_S,
  RD_DATA_S,
  NACK_S,
  STOP_S
} state_t;

state_t        state;
state_t        next_state;

logic          wr_req;
logic          rd_req;
logic          accept;
logic          is_read;
logic          err_flag;
logic          byte_end;
logic          to_idle;
logic          ack_phase;
logic          tx_phase;
logic          byte_phase;
logic [15 : 0] sub_addr;
logic [7 : 0]  wr_byte;
logic [7 : 0]  shift_tx;
logic [7 : 0]  shift_rx;
logic [2 : 0]  bit_cnt;

// A write needs both address and data beats in the same cycle
assign wr_req = s_awvalid_i && s_wvalid_i;
assign rd_req = s_arvalid_i && !wr_req;
assign accept = ( state == IDLE_S ) && ( wr_req || rd_req );

assign s_awready_o = state == IDLE_S;
assign s_wready_o  = state == IDLE_S;
assign s_arready_o = state == IDLE_S;

assign ack_phase  = ( state == ACK_0_S ) || ( state == ACK_1_S ) ||
                    ( state == ACK_2_S ) || ( state == ACK_3_S );
assign tx_phase   = ( state == SLAVE_ADDR_0_S ) || ( state == SUB_ADDR_MSB_S ) ||
                    ( state == SUB_ADDR_LSB_S ) || ( state == SLAVE_ADDR_1_S ) ||
                    ( state == WR_DATA_S );
assign byte_phase = tx_phase || ( state == RD_DATA_S );
assign byte_end   = cmd_done_i && ( bit_cnt == 3'd7 );
assign to_idle    = ( state != IDLE_S ) && ( next_state == IDLE_S );

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    state <= IDLE_S;
  else
    state <= next_state;

// Any ACK phase that sees the line released goes straight to STOP
always_comb
  begin
    next_state = state;
    case( state )
      IDLE_S:         if( wr_req || rd_req ) next_state = START_0_S;
      START_0_S:      if( cmd_done_i )       next_state = SLAVE_ADDR_0_S;
      SLAVE_ADDR_0_S: if( byte_end )         next_state = ACK_0_S;
      ACK_0_S:        if( cmd_done_i )       next_state = rx_bit_i ? STOP_S : SUB_ADDR_MSB_S;
      SUB_ADDR_MSB_S: if( byte_end )         next_state = ACK_1_S;
      ACK_1_S:        if( cmd_done_i )       next_state = rx_bit_i ? STOP_S : SUB_ADDR_LSB_S;
      SUB_ADDR_LSB_S: if( byte_end )         next_state = ACK_2_S;
      ACK_2_S:
        begin
          if( cmd_done_i )
            if( rx_bit_i )
              next_state = STOP_S;
            else
              next_state = is_read ? START_1_S : WR_DATA_S;
        end
      START_1_S:      if( cmd_done_i )       next_state = SLAVE_ADDR_1_S;
      SLAVE_ADDR_1_S: if( byte_end )         next_state = ACK_3_S;
      ACK_3_S:        if( cmd_done_i )       next_state = rx_bit_i ? STOP_S : RD_DATA_S;
      WR_DATA_S:      if( byte_end )         next_state = NACK_S;
      RD_DATA_S:      if( byte_end )         next_state = NACK_S;
      NACK_S:         if( cmd_done_i )       next_state = STOP_S;
      STOP_S:         if( cmd_done_i )       next_state = IDLE_S;
      default:                               next_state = IDLE_S;
    endcase
  end

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      is_read  <= 1'b0;
      err_flag <= 1'b0;
    end
  else
    if( accept )
      begin
        is_read  <= rd_req;
        err_flag <= 1'b0;
      end
    else
      if( ack_phase && cmd_done_i && rx_bit_i )
        err_flag <= 1'b1;

always_ff @( posedge clk_i )
  if( accept )
    begin
      sub_addr <= wr_req ? s_awaddr_i[15 : 0] : s_araddr_i[15 : 0];
      if( wr_req )
        wr_byte <= s_wdata_i[7 : 0];
    end

// Bytes always end on a wrap, so each phase starts from zero
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    bit_cnt <= '0;
  else
    if( byte_phase && cmd_done_i )
      bit_cnt <= bit_cnt + 3'd1;

always_ff @( posedge clk_i )
  if( next_state != state )
    case( next_state )
      SLAVE_ADDR_0_S: shift_tx <= { slave_addr_i, 1'b0 };
      SLAVE_ADDR_1_S: shift_tx <= { slave_addr_i, 1'b1 };
      SUB_ADDR_MSB_S: shift_tx <= sub_addr[15 : 8];
      SUB_ADDR_LSB_S: shift_tx <= sub_addr[7 : 0];
      WR_DATA_S:      shift_tx <= wr_byte;
      NACK_S:         shift_tx <= 8'h80;
      default:        shift_tx <= shift_tx;
    endcase
  else
    if( tx_phase && cmd_done_i )
      shift_tx <= { shift_tx[6 : 0], 1'b0 };

assign tx_bit_o = shift_tx[7];

always_ff @( posedge clk_i )
  if( ( state == RD_DATA_S ) && cmd_done_i )
    shift_rx <= { shift_rx[6 : 0], rx_bit_i };

always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    phy_cmd_o <= sccb_pkg::NOP;
  else
    case( next_state )
      START_0_S,
      START_1_S:      phy_cmd_o <= sccb_pkg::START;
      SLAVE_ADDR_0_S,
      SUB_ADDR_MSB_S,
      SUB_ADDR_LSB_S,
      SLAVE_ADDR_1_S,
      WR_DATA_S,
      NACK_S:         phy_cmd_o <= sccb_pkg::WRITE;
      ACK_0_S,
      ACK_1_S,
      ACK_2_S,
      ACK_3_S,
      RD_DATA_S:      phy_cmd_o <= sccb_pkg::READ;
      STOP_S:         phy_cmd_o <= sccb_pkg::STOP;
      default:        phy_cmd_o <= sccb_pkg::NOP;
    endcase

// Completion wins over a ready seen in the same cycle
always_ff @( posedge clk_i, posedge srst_i )
  if( srst_i )
    begin
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
    end
  else
    begin
      if( to_idle && !is_read )
        s_bvalid_o <= 1'b1;
      else
        if( s_bready_i )
          s_bvalid_o <= 1'b0;

      if( to_idle && is_read )
        s_rvalid_o <= 1'b1;
      else
        if( s_rready_i )
          s_rvalid_o <= 1'b0;
    end

always_ff @( posedge clk_i )
  if( to_idle )
    begin
      if( is_read )
        begin
          s_rresp_o <= err_flag ? sccb_pkg::RESP_SLVERR : sccb_pkg::RESP_OKAY;
          s_rdata_o <= err_flag ? '0 : { {( sccb_pkg::AXI_DATA_W - 8 ){1'b0}}, shift_rx };
        end
      else
        s_bresp_o <= err_flag ? sccb_pkg::RESP_SLVERR : sccb_pkg::RESP_OKAY;
    end

endmodule

`default_nettype wire

// ==== verilog/sccb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module sccb_top (
  input  wire                                  clk_i,
  input  wire                                  srst_i,
  input  wire                                  s_awvalid_i,
  output logic                                 s_awready_o,
  input  wire  [sccb_pkg::AXI_ADDR_W - 1 : 0]  s_awaddr_i,
  input  wire                                  s_wvalid_i,
  output logic                                 s_wready_o,
  input  wire  [sccb_pkg::AXI_DATA_W - 1 : 0]  s_wdata_i,
  output logic                                 s_bvalid_o,
  input  wire                                  s_bready_i,
  output logic [1 : 0]                         s_bresp_o,
  input  wire                                  s_arvalid_i,
  output logic                                 s_arready_o,
  input  wire  [sccb_pkg::AXI_ADDR_W - 1 : 0]  s_araddr_i,
  output logic                                 s_rvalid_o,
  input  wire                                  s_rready_i,
  output logic [sccb_pkg::AXI_DATA_W - 1 : 0]  s_rdata_o,
  output logic [1 : 0]                         s_rresp_o,
  input  wire  [6 : 0]                         slave_addr_i,
  input  wire                                  sda_i,
  output logic                                 sda_o,
  output logic                                 sda_oe_o,
  input  wire                                  scl_i,
  output logic                                 scl_o,
  output logic                                 scl_oe_o
);

sccb_pkg::phy_cmd_t phy_cmd;
logic               tx_bit;
logic               rx_bit;
logic               cmd_done;

sccb_master sccb_master0 (
  .clk_i        ( clk_i        ),
  .srst_i       ( srst_i       ),
  .s_awvalid_i  ( s_awvalid_i  ),
  .s_awready_o  ( s_awready_o  ),
  .s_awaddr_i   ( s_awaddr_i   ),
  .s_wvalid_i   ( s_wvalid_i   ),
  .s_wready_o   ( s_wready_o   ),
  .s_wdata_i    ( s_wdata_i    ),
  .s_bvalid_o   ( s_bvalid_o   ),
  .s_bready_i   ( s_bready_i   ),
  .s_bresp_o    ( s_bresp_o    ),
  .s_arvalid_i  ( s_arvalid_i  ),
  .s_arready_o  ( s_arready_o  ),
  .s_araddr_i   ( s_araddr_i   ),
  .s_rvalid_o   ( s_rvalid_o   ),
  .s_rready_i   ( s_rready_i   ),
  .s_rdata_o    ( s_rdata_o    ),
  .s_rresp_o    ( s_rresp_o    ),
  .slave_addr_i ( slave_addr_i ),
  .phy_cmd_o    ( phy_cmd      ),
  .tx_bit_o     ( tx_bit       ),
  .rx_bit_i     ( rx_bit       ),
  .cmd_done_i   ( cmd_done     )
);

i2c_master_phy i2c_master_phy0 (
  .clk_i        ( clk_i        ),
  .srst_i       ( srst_i       ),
  .cmd_i        ( phy_cmd      ),
  .data_i       ( tx_bit       ),
  .data_o       ( rx_bit       ),
  .cmd_done_o   ( cmd_done     ),
  .sda_i        ( sda_i        ),
  .sda_o        ( sda_o        ),
  .sda_oe_o     ( sda_oe_o     ),
  .scl_i        ( scl_i        ),
  .scl_o        ( scl_o        ),
  .scl_oe_o     ( scl_oe_o     )
);

endmodule

`default_nettype wire

// ==== verif/sccb_slave_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module sccb_slave_model #(
  parameter logic [6 : 0] DEV_ADDR = 7'h21,
  parameter logic [7 : 0] FILL_XOR = 8'ha5
) (
  input  wire  scl_i,
  input  wire  sda_i,
  output logic sda_oe_o
);

logic [7 : 0] mem [0 : 255];
logic [7 : 0] shift_in;
logic [7 : 0] tx_byte;
logic [7 : 0] sub_lsb;
logic [3 : 0] bit_cnt;
logic [1 : 0] byte_idx;
logic         active;
logic         selected;
logic         tx_active;
logic         ack_due;
logic         scl_q;
logic         sda_q;

initial
  begin
    for( int i = 0; i < 256; i++ )
      mem[i] = 8'( i ) ^ FILL_XOR;
    sda_oe_o  = 1'b0;
    active    = 1'b0;
    selected  = 1'b0;
    tx_active = 1'b0;
    ack_due   = 1'b0;
    bit_cnt   = '0;
    byte_idx  = '0;
    shift_in  = '0;
    tx_byte   = '0;
    sub_lsb   = '0;
    scl_q     = 1'b1;
    sda_q     = 1'b1;
  end

// Byte order in a frame is device address, sub-address MSB, LSB, then data
task automatic take_byte();
  ack_due = 1'b0;
  if( tx_active )
    tx_active = 1'b0;
  else
    case( byte_idx )
      2'd0:
        begin
          selected = shift_in[7 : 1] == DEV_ADDR;
          ack_due  = selected;
          if( selected && shift_in[0] )
            begin
              tx_active = 1'b1;
              tx_byte   = mem[sub_lsb];
            end
        end
      2'd1:
        ack_due = selected;
      2'd2:
        begin
          if( selected )
            sub_lsb = shift_in;
          ack_due = selected;
        end
      default:
        if( selected )
          mem[sub_lsb] = shift_in;
    endcase
  if( byte_idx != 2'd3 )
    byte_idx = byte_idx + 2'd1;
endtask

task automatic start_seen();
  active    = 1'b1;
  bit_cnt   = '0;
  byte_idx  = '0;
  ack_due   = 1'b0;
  tx_active = 1'b0;
  sda_oe_o  = 1'b0;
endtask

task automatic stop_seen();
  active   = 1'b0;
  selected = 1'b0;
  sda_oe_o = 1'b0;
endtask

// Bit 8 of the count is the ninth clock, the ACK slot
task automatic scl_rise();
  if( active )
    if( bit_cnt == 4'd8 )
      bit_cnt = '0;
    else
      begin
        shift_in = { shift_in[6 : 0], sda_i };
        bit_cnt  = bit_cnt + 4'd1;
        if( bit_cnt == 4'd8 )
          take_byte();
      end
endtask

// SDA only changes here, while SCL is low
task automatic scl_fall();
  if( active )
    if( bit_cnt == 4'd8 )
      sda_oe_o = ack_due;
    else
      sda_oe_o = tx_active && !tx_byte[3'd7 - bit_cnt[2 : 0]];
endtask

always @( scl_i, sda_i )
  begin
    if( ( scl_q === 1'b1 ) && ( scl_i === 1'b1 ) && ( sda_q === 1'b1 ) && ( sda_i === 1'b0 ) )
      start_seen();
    else
      if( ( scl_q === 1'b1 ) && ( scl_i === 1'b1 ) && ( sda_q === 1'b0 ) && ( sda_i === 1'b1 ) )
        stop_seen();
      else
        if( ( scl_q === 1'b0 ) && ( scl_i === 1'b1 ) )
          scl_rise();
        else
          if( ( scl_q === 1'b1 ) && ( scl_i === 1'b0 ) )
            scl_fall();
    scl_q = scl_i;
    sda_q = sda_i;
  end

endmodule

`default_nettype wire

// ==== verif/tb_sccb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_sccb_top;

localparam int NUM_FIXED      = 10;
localparam int NUM_RANDOM     = 14;
localparam int NUM_ENTRIES    = NUM_FIXED + NUM_RANDOM;
localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 48 * 4 * sccb_pkg::SCL_QUARTER * 2;

localparam logic [6 : 0] SENSOR_ADDR = 7'h21;
localparam logic [6 : 0] OTHER_ADDR  = 7'h42;
localparam logic [7 : 0] FILL_XOR    = 8'ha5;

typedef struct packed {
  logic          is_read;
  logic [6 : 0]  dev_addr;
  logic [15 : 0] sub_addr;
  logic [7 : 0]  wr_data;
  logic [3 : 0]  ready_delay;
  logic [1 : 0]  resp;
} entry_t;

logic                                 clk = 1'b0;
logic                                 srst;
logic                                 s_awvalid;
logic [sccb_pkg::AXI_ADDR_W - 1 : 0]  s_awaddr;
logic                                 s_wvalid;
logic [sccb_pkg::AXI_DATA_W - 1 : 0]  s_wdata;
logic                                 s_bready;
logic                                 s_arvalid;
logic [sccb_pkg::AXI_ADDR_W - 1 : 0]  s_araddr;
logic                                 s_rready;
logic [6 : 0]                         slave_addr;
logic                                 s_awready;
logic                                 s_wready;
logic                                 s_bvalid;
logic [1 : 0]                         s_bresp;
logic                                 s_arready;
logic                                 s_rvalid;
logic [sccb_pkg::AXI_DATA_W - 1 : 0]  s_rdata;
logic [1 : 0]                         s_rresp;
logic                                 dut_sda_o;
logic                                 dut_sda_oe;
logic                                 dut_scl_o;
logic                                 dut_scl_oe;
logic                                 slave_sda_oe;
wire                                  sda_line;
wire                                  scl_line;

entry_t       stim [0 : NUM_ENTRIES - 1];
logic [7 : 0] shadow [0 : 255];
logic [31 : 0] rnd;
int           errors;
int           checks;
int           cycle_cnt;

// Open-drain bus, either side can pull a line low
assign sda_line = ( dut_sda_oe ? dut_sda_o : 1'b1 ) & !slave_sda_oe;
assign scl_line = dut_scl_oe ? dut_scl_o : 1'b1;

always #50 clk = !clk;

sccb_top dut0 (
  .clk_i        ( clk          ),
  .srst_i       ( srst         ),
  .s_awvalid_i  ( s_awvalid    ),
  .s_awready_o  ( s_awready    ),
  .s_awaddr_i   ( s_awaddr     ),
  .s_wvalid_i   ( s_wvalid     ),
  .s_wready_o   ( s_wready     ),
  .s_wdata_i    ( s_wdata      ),
  .s_bvalid_o   ( s_bvalid     ),
  .s_bready_i   ( s_bready     ),
  .s_bresp_o    ( s_bresp      ),
  .s_arvalid_i  ( s_arvalid    ),
  .s_arready_o  ( s_arready    ),
  .s_araddr_i   ( s_araddr     ),
  .s_rvalid_o   ( s_rvalid     ),
  .s_rready_i   ( s_rready     ),
  .s_rdata_o    ( s_rdata      ),
  .s_rresp_o    ( s_rresp      ),
  .slave_addr_i ( slave_addr   ),
  .sda_i        ( sda_line     ),
  .sda_o        ( dut_sda_o    ),
  .sda_oe_o     ( dut_sda_oe   ),
  .scl_i        ( scl_line     ),
  .scl_o        ( dut_scl_o    ),
  .scl_oe_o     ( dut_scl_oe   )
);

sccb_slave_model #(
  .DEV_ADDR ( SENSOR_ADDR ),
  .FILL_XOR ( FILL_XOR    )
) slave0 (
  .scl_i    ( scl_line     ),
  .sda_i    ( sda_line     ),
  .sda_oe_o ( slave_sda_oe )
);

task automatic check_value(
  input string         what,
  input logic [31 : 0] got,
  input logic [31 : 0] exp
);
  checks = checks + 1;
  if( got !== exp )
    begin
      errors = errors + 1;
      $display( "ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp );
    end
endtask

function automatic entry_t make_entry(
  input logic          is_read,
  input logic [6 : 0]  dev_addr,
  input logic [15 : 0] sub_addr,
  input logic [7 : 0]  wr_data,
  input logic [3 : 0]  ready_delay,
  input logic [1 : 0]  resp
);
  entry_t e;
  e.is_read     = is_read;
  e.dev_addr    = dev_addr;
  e.sub_addr    = sub_addr;
  e.wr_data     = wr_data;
  e.ready_delay = ready_delay;
  e.resp        = resp;
  return e;
endfunction

// Random reads reuse the previous low byte under a fresh MSB
task automatic build_stimulus();
  logic [15 : 0] last_sub;
  logic [15 : 0] sub;
  stim[0] = make_entry( 1'b0, SENSOR_ADDR, 16'h0012, 8'h3c, 4'd0, sccb_pkg::RESP_OKAY   );
  stim[1] = make_entry( 1'b1, SENSOR_ADDR, 16'h0012, 8'h00, 4'd0, sccb_pkg::RESP_OKAY   );
  stim[2] = make_entry( 1'b0, SENSOR_ADDR, 16'h12a7, 8'h00, 4'd3, sccb_pkg::RESP_OKAY   );
  stim[3] = make_entry( 1'b1, SENSOR_ADDR, 16'h12a7, 8'h00, 4'd5, sccb_pkg::RESP_OKAY   );
  stim[4] = make_entry( 1'b0, OTHER_ADDR,  16'h0012, 8'h99, 4'd0, sccb_pkg::RESP_SLVERR );
  stim[5] = make_entry( 1'b1, OTHER_ADDR,  16'h0012, 8'h00, 4'd2, sccb_pkg::RESP_SLVERR );
  stim[6] = make_entry( 1'b1, SENSOR_ADDR, 16'h0012, 8'h00, 4'd0, sccb_pkg::RESP_OKAY   );
  stim[7] = make_entry( 1'b1, SENSOR_ADDR, 16'h00f0, 8'h00, 4'd1, sccb_pkg::RESP_OKAY   );
  stim[8] = make_entry( 1'b0, SENSOR_ADDR, 16'h8055, 8'ha5, 4'd7, sccb_pkg::RESP_OKAY   );
  stim[9] = make_entry( 1'b1, SENSOR_ADDR, 16'h7f55, 8'h00, 4'd0, sccb_pkg::RESP_OKAY   );
  last_sub = 16'h7f55;
  for( int n = NUM_FIXED; n < NUM_ENTRIES; n++ )
    begin
      rnd = $urandom;
      sub = rnd[0] ? { rnd[15 : 8], last_sub[7 : 0] } : rnd[31 : 16];
      stim[n]  = make_entry( rnd[0], SENSOR_ADDR, sub, 8'h00, { 2'b00, rnd[5 : 4] },
                             sccb_pkg::RESP_OKAY );
      last_sub = sub;
    end
endtask

task automatic check_reset_state( input string when );
  check_value( { "bvalid ", when }, s_bvalid, 1'b0 );
  check_value( { "rvalid ", when }, s_rvalid, 1'b0 );
  check_value( { "sda_oe ", when }, dut_sda_oe, 1'b0 );
  check_value( { "scl_oe ", when }, dut_scl_oe, 1'b0 );
  check_value( { "awready ", when }, s_awready, 1'b1 );
  check_value( { "wready ", when }, s_wready, 1'b1 );
  check_value( { "arready ", when }, s_arready, 1'b1 );
endtask

task automatic await_valid( input logic is_read );
  logic seen;
  seen = 1'b0;
  while( !seen )
    begin
      @( negedge clk );
      seen = is_read ? s_rvalid : s_bvalid;
      if( !seen )
        begin
          check_value( "awready while busy", s_awready, 1'b0 );
          check_value( "wready while busy", s_wready, 1'b0 );
          check_value( "arready while busy", s_arready, 1'b0 );
          check_value( "sda_o while busy", dut_sda_o, 1'b0 );
          check_value( "scl_o while busy", dut_scl_o, 1'b0 );
        end
    end
endtask

task automatic run_write( input entry_t e );
  logic [7 : 0] data;
  logic [1 : 0] resp_seen;
  logic         taken;
  rnd  = $urandom;
  data = ( e.wr_data == 8'h00 ) ? rnd[7 : 0] : e.wr_data;
  @( posedge clk );
  slave_addr <= e.dev_addr;
  s_awaddr   <= e.sub_addr;
  s_wdata    <= { 24'h0, data };
  s_awvalid  <= 1'b1;
  s_wvalid   <= 1'b1;
  taken = 1'b0;
  while( !taken )
    begin
      @( negedge clk );
      taken = s_awready && s_wready;
      @( posedge clk );
    end
  s_awvalid <= 1'b0;
  s_wvalid  <= 1'b0;
  await_valid( 1'b0 );
  resp_seen = s_bresp;
  check_value( "bresp", s_bresp, e.resp );
  if( e.resp == sccb_pkg::RESP_OKAY )
    shadow[e.sub_addr[7 : 0]] = data;
  repeat( e.ready_delay )
    begin
      @( negedge clk );
      check_value( "bvalid under back-pressure", s_bvalid, 1'b1 );
      check_value( "bresp under back-pressure", s_bresp, resp_seen );
    end
  @( posedge clk );
  s_bready <= 1'b1;
  @( posedge clk );
  s_bready <= 1'b0;
  @( negedge clk );
  check_value( "bvalid after handshake", s_bvalid, 1'b0 );
endtask

task automatic run_read( input entry_t e );
  logic [31 : 0] exp_data;
  logic [31 : 0] data_seen;
  logic [1 : 0]  resp_seen;
  logic          taken;
  exp_data = ( e.resp == sccb_pkg::RESP_OKAY ) ? { 24'h0, shadow[e.sub_addr[7 : 0]] } : 32'h0;
  @( posedge clk );
  slave_addr <= e.dev_addr;
  s_araddr   <= e.sub_addr;
  s_arvalid  <= 1'b1;
  taken = 1'b0;
  while( !taken )
    begin
      @( negedge clk );
      taken = s_arready;
      @( posedge clk );
    end
  s_arvalid <= 1'b0;
  await_valid( 1'b1 );
  resp_seen = s_rresp;
  data_seen = s_rdata;
  check_value( "rresp", s_rresp, e.resp );
  check_value( "rdata", s_rdata, exp_data );
  repeat( e.ready_delay )
    begin
      @( negedge clk );
      check_value( "rvalid under back-pressure", s_rvalid, 1'b1 );
      check_value( "rresp under back-pressure", s_rresp, resp_seen );
      check_value( "rdata under back-pressure", s_rdata, data_seen );
    end
  @( posedge clk );
  s_rready <= 1'b1;
  @( posedge clk );
  s_rready <= 1'b0;
  @( negedge clk );
  check_value( "rvalid after handshake", s_rvalid, 1'b0 );
endtask

initial
  begin
    cycle_cnt = 0;
    while( cycle_cnt < TIMEOUT_CYCLES )
      begin
        @( posedge clk );
        cycle_cnt = cycle_cnt + 1;
      end
    $display( "Timeout after %0d clock cycles, an access never completed", cycle_cnt );
    $display( "*** FAILED ***" );
    $finish;
  end

initial
  begin
    srst       <= 1'b1;
    s_awvalid  <= 1'b0;
    s_awaddr   <= '0;
    s_wvalid   <= 1'b0;
    s_wdata    <= '0;
    s_bready   <= 1'b0;
    s_arvalid  <= 1'b0;
    s_araddr   <= '0;
    s_rready   <= 1'b0;
    slave_addr <= SENSOR_ADDR;
    errors = 0;
    checks = 0;
    rnd    = $urandom( 32'hf051 );
    build_stimulus();
    // Sensor powers up with each register holding its index XOR the fill value
    for( int i = 0; i < 256; i++ )
      shadow[i] = 8'( i ) ^ FILL_XOR;
    @( negedge clk );
    check_reset_state( "during reset" );
    repeat( 3 ) @( posedge clk );
    srst <= 1'b0;
    @( negedge clk );
    check_reset_state( "after reset" );
    for( int n = 0; n < NUM_ENTRIES; n++ )
      if( stim[n].is_read )
        run_read( stim[n] );
      else
        run_write( stim[n] );
    $display( "Finished %0d accesses: %0d checks, %0d errors", NUM_ENTRIES, checks, errors );
    if( errors == 0 )
      $display( "*** PASSED ***" );
    else
      $display( "*** FAILED ***" );
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/sccb_pkg.sv
i2c_phy/i2c_master_phy.sv
sccb_master/sccb_master.sv
verilog/sccb_top.sv
verif/sccb_slave_model.sv
verif/tb_sccb_top.sv
